// ==== hdl/mmio_pkg.sv ====
// Address map and timing constants. ram_latency must be 2 or more; the dividers must be at least 1.
`default_nettype none

package mmio_pkg;

	localparam int data_w = 16;
	localparam int addr_w = 16;

	// register map below ram_base
	localparam logic [addr_w-1:0] addr_buttons     = 16'h0000;
	localparam logic [addr_w-1:0] addr_uart_data   = 16'h0001;
	localparam logic [addr_w-1:0] addr_uart_stat   = 16'h0002;
	localparam logic [addr_w-1:0] addr_spi_data    = 16'h0004;
	localparam logic [addr_w-1:0] addr_spi_cs      = 16'h0005;
	localparam logic [addr_w-1:0] addr_tone_period = 16'h0006;
	localparam logic [addr_w-1:0] addr_tone_en     = 16'h0007;

	// backing memory, low address bits only so the region aliases
	localparam logic [addr_w-1:0] ram_base = 16'h0100;
	localparam int ram_depth_log2 = 8;

	// clocks per uart bit, clocks per spi half-bit
	localparam int uart_div = 8;
	localparam int spi_div  = 2;

	// cycles from strobe to ready
	localparam int ram_latency = 3;

	// counter widths and terminal values derived from the above
	localparam int uart_cnt_w = $clog2(uart_div + 1);
	localparam logic [uart_cnt_w-1:0] uart_bit_last = uart_cnt_w'(uart_div - 1);
	localparam logic [uart_cnt_w-1:0] uart_bit_half = uart_cnt_w'(uart_div / 2 - 1);

	localparam int spi_cnt_w = $clog2(spi_div + 1);
	localparam logic [spi_cnt_w-1:0] spi_half_last = spi_cnt_w'(spi_div - 1);

	localparam int ram_cnt_w = $clog2(ram_latency + 1);
	localparam logic [ram_cnt_w-1:0] ram_lat_last = ram_cnt_w'(ram_latency - 2);

endpackage

`default_nettype wire

// ==== hdl/mem_bus_if.sv ====
// Backing-memory request and response; addr is the word index inside the RAM region only.
`default_nettype none

interface mem_bus_if;

	logic [mmio_pkg::ram_depth_log2-1:0] addr;
	logic [mmio_pkg::data_w-1:0]         wdata;
	logic [mmio_pkg::data_w-1:0]         rdata;
	logic                                read;
	logic                                write;
	// levels, not pulses
	logic                                busy;
	logic                                ready;

	modport ctrl (
		output addr, wdata, read, write,
		input  rdata, busy, ready
	);

	modport mem (
		input  addr, wdata, read, write,
		output rdata, busy, ready
	);

endinterface

`default_nettype wire

// ==== hdl/io_decoder.sv ====
// Host strobes must be one-cycle pulses; strobes arriving while a RAM access is outstanding are dropped.
`default_nettype none

module io_decoder (
	input  logic                        clki,
	input  logic                        rst_in,
	input  logic [mmio_pkg::addr_w-1:0] addr,
	input  logic [mmio_pkg::data_w-1:0] wdata,
	input  logic                        read,
	input  logic                        write,
	input  logic [7:0]                  buttons,
	input  logic [7:0]                  rx_data,
	input  logic                        rx_new,
	input  logic                        tx_ready,
	input  logic [7:0]                  spi_rx,
	input  logic                        spi_ready,
	output logic [mmio_pkg::data_w-1:0] rdata,
	output logic                        ready,
	output logic                        busy,
	output logic                        uart_write,
	output logic                        uart_read,
	output logic                        spi_write,
	output logic                        spi_cs_write,
	output logic                        tone_period_write,
	output logic                        tone_en_write,
	mem_bus_if.ctrl                     mem
);

	logic pending;
	logic blocked;
	logic is_ram;
	logic acc_read;
	logic acc_write;
	logic mem_read;
	logic mem_write;

	// outstanding until the RAM raises ready again
	assign blocked   = pending && !mem.ready;
	assign is_ram    = (addr >= mmio_pkg::ram_base);
	assign acc_read  = read && !blocked;
	assign acc_write = write && !blocked;

	assign ready = !blocked;
	assign busy  = mem.busy;

	assign mem.addr  = addr[mmio_pkg::ram_depth_log2-1:0];
	assign mem.wdata = wdata;
	assign mem.read  = mem_read;
	assign mem.write = mem_write;

	always_ff @(posedge clki) begin
		if (!rst_in) begin
			pending <= 1'b0;
		end else if (mem_read || mem_write) begin
			pending <= 1'b1;
		end else if (mem.ready) begin
			pending <= 1'b0;
		end
	end

	always_comb begin
		rdata             = '0;
		mem_read          = 1'b0;
		mem_write         = 1'b0;
		uart_write        = 1'b0;
		uart_read         = 1'b0;
		spi_write         = 1'b0;
		spi_cs_write      = 1'b0;
		tone_period_write = 1'b0;
		tone_en_write     = 1'b0;
		if (is_ram) begin
			rdata     = mem.rdata;
			mem_read  = acc_read;
			mem_write = acc_write;
		end else begin
			case (addr)
				mmio_pkg::addr_buttons: begin
					rdata[7:0] = buttons;
				end
				mmio_pkg::addr_uart_data: begin
					rdata[7:0] = rx_data;
					uart_write = acc_write;
					uart_read  = acc_read;
				end
				mmio_pkg::addr_uart_stat: begin
					rdata[1:0] = {tx_ready, rx_new};
				end
				mmio_pkg::addr_spi_data: begin
					rdata[mmio_pkg::data_w-1] = spi_ready;
					rdata[7:0]                = spi_rx;
					spi_write                 = acc_write;
				end
				mmio_pkg::addr_spi_cs:      spi_cs_write      = acc_write;
				mmio_pkg::addr_tone_period: tone_period_write = acc_write;
				mmio_pkg::addr_tone_en:     tone_en_write     = acc_write;
				// unmapped registers read zero
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/uart_port.sv ====
// 8N1 only, no parity or framing error report; a write while tx_ready is low is lost.
`default_nettype none

module uart_port (
	input  logic       clki,
	input  logic       rst_in,
	input  logic       uart_rx,
	input  logic [7:0] tx_byte,
	input  logic       uart_write,
	input  logic       uart_read,
	output logic       uart_tx,
	output logic [7:0] rx_data,
	output logic       rx_new,
	output logic       tx_ready
);

	logic [9:0]                      tx_shift;
	logic [3:0]                      tx_bits;
	logic [mmio_pkg::uart_cnt_w-1:0] tx_div;
	logic                            tx_busy;

	logic [1:0]                      rx_sync;
	logic                            rx_line;
	logic                            rx_busy;
	logic                            rx_tick;
	logic [3:0]                      rx_bits;
	logic [mmio_pkg::uart_cnt_w-1:0] rx_div;
	logic [7:0]                      rx_shift;

	assign uart_tx  = tx_shift[0];
	assign tx_ready = !tx_busy;

	// stop, data lsb first, start
	always_ff @(posedge clki) begin
		if (!rst_in) begin
			tx_shift <= '1;
			tx_bits  <= '0;
			tx_div   <= '0;
			tx_busy  <= 1'b0;
		end else if (!tx_busy) begin
			if (uart_write) begin
				tx_shift <= {1'b1, tx_byte, 1'b0};
				tx_bits  <= '0;
				tx_div   <= '0;
				tx_busy  <= 1'b1;
			end
		end else if (tx_div == mmio_pkg::uart_bit_last) begin
			tx_div   <= '0;
			tx_shift <= {1'b1, tx_shift[9:1]};
			if (tx_bits == 4'd9) begin
				tx_busy <= 1'b0;
			end else begin
				tx_bits <= tx_bits + 1'b1;
			end
		end else begin
			tx_div <= tx_div + 1'b1;
		end
	end

	assign rx_line = rx_sync[1];
	// mid-bit sample point
	assign rx_tick = rx_busy && (rx_div == '0);

	always_ff @(posedge clki) begin
		if (!rst_in) begin
			rx_sync <= 2'b11;
			rx_busy <= 1'b0;
			rx_bits <= '0;
			rx_div  <= '0;
			rx_new  <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], uart_rx};
			if (uart_read) begin
				rx_new <= 1'b0;
			end
			if (!rx_busy) begin
				if (!rx_line) begin
					rx_busy <= 1'b1;
					rx_bits <= '0;
					rx_div  <= mmio_pkg::uart_bit_half;
				end
			end else if (!rx_tick) begin
				rx_div <= rx_div - 1'b1;
			end else begin
				rx_div  <= mmio_pkg::uart_bit_last;
				rx_bits <= rx_bits + 1'b1;
				if (rx_bits == 4'd0 && rx_line) begin
					// glitch, not a start bit
					rx_busy <= 1'b0;
				end else if (rx_bits == 4'd9) begin
					rx_busy <= 1'b0;
					if (rx_line) begin
						rx_new <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clki) begin
		if (rx_tick) begin
			if (rx_bits != 4'd0 && rx_bits != 4'd9) begin
				rx_shift <= {rx_line, rx_shift[7:1]};
			end
			if (rx_bits == 4'd9 && rx_line) begin
				rx_data <= rx_shift;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/spi_master.sv ====
// Mode 0, MSB first, one byte per write; chip select is only moved by software.
`default_nettype none

module spi_master (
	input  logic       clki,
	input  logic       rst_in,
	input  logic [7:0] tx_byte,
	input  logic       spi_write,
	input  logic       spi_cs_write,
	input  logic       cs_bit,
	input  logic       spi_miso,
	output logic       spi_clk,
	output logic       spi_mosi,
	output logic       spi_cs,
	output logic [7:0] spi_rx,
	output logic       spi_ready
);

	logic [7:0]                     tx_shift;
	logic [7:0]                     rx_shift;
	logic [3:0]                     half_cnt;
	logic [mmio_pkg::spi_cnt_w-1:0] div_cnt;
	logic                           busy;
	logic                           clk_q;
	logic                           cs_q;

	assign spi_clk   = clk_q;
	assign spi_mosi  = tx_shift[7];
	assign spi_cs    = cs_q;
	assign spi_rx    = rx_shift;
	assign spi_ready = !busy;

	always_ff @(posedge clki) begin
		if (!rst_in) begin
			tx_shift <= '0;
			rx_shift <= '0;
			half_cnt <= '0;
			div_cnt  <= '0;
			busy     <= 1'b0;
			clk_q    <= 1'b0;
			cs_q     <= 1'b1;
		end else begin
			if (spi_cs_write) begin
				cs_q <= cs_bit;
			end
			if (!busy) begin
				if (spi_write) begin
					tx_shift <= tx_byte;
					half_cnt <= '0;
					div_cnt  <= '0;
					busy     <= 1'b1;
				end
			end else if (div_cnt != mmio_pkg::spi_half_last) begin
				div_cnt <= div_cnt + 1'b1;
			end else begin
				div_cnt  <= '0;
				half_cnt <= half_cnt + 1'b1;
				clk_q    <= !clk_q;
				// sample on rise, shift out on fall
				if (!clk_q) begin
					rx_shift <= {rx_shift[6:0], spi_miso};
				end else begin
					tx_shift <= {tx_shift[6:0], 1'b0};
				end
				if (half_cnt == 4'd15) begin
					busy <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tone_gen.sv ====
// Square wave of 2*(period+1) clocks; a period of zero toggles every clock.
`default_nettype none

module tone_gen (
	input  logic                        clki,
	input  logic                        rst_in,
	input  logic [mmio_pkg::data_w-1:0] wdata,
	input  logic                        tone_period_write,
	input  logic                        tone_en_write,
	output logic                        freq_out
);

	logic [mmio_pkg::data_w-1:0] period;
	logic [mmio_pkg::data_w-1:0] period_next;
	logic [mmio_pkg::data_w-1:0] count;
	logic                        enable;
	logic                        en_next;
	logic                        freq_q;

	// new settings act in the cycle they are written
	assign period_next = tone_period_write ? wdata : period;
	assign en_next     = tone_en_write ? wdata[0] : enable;
	assign freq_out    = freq_q;

	always_ff @(posedge clki) begin
		if (!rst_in) begin
			period <= '0;
			count  <= '0;
			enable <= 1'b0;
			freq_q <= 1'b0;
		end else begin
			period <= period_next;
			enable <= en_next;
			if (!en_next) begin
				freq_q <= 1'b0;
				count  <= period_next;
			end else if (count == '0) begin
				freq_q <= !freq_q;
				count  <= period;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/wait_ram.sv ====
// Fixed latency, one access at a time; contents are undefined after power-up and survive reset.
`default_nettype none

module wait_ram (
	input  logic   clki,
	input  logic   rst_in,
	mem_bus_if.mem mem
);

	logic [mmio_pkg::data_w-1:0]         mem_array [0:(1 << mmio_pkg::ram_depth_log2) - 1];
	logic [mmio_pkg::ram_depth_log2-1:0] req_addr;
	logic [mmio_pkg::data_w-1:0]         req_wdata;
	logic                                req_write;
	logic [mmio_pkg::data_w-1:0]         rdata_q;
	logic [mmio_pkg::ram_cnt_w-1:0]      lat_cnt;
	logic                                busy_q;
	logic                                start;
	logic                                done;

	assign start = !busy_q && (mem.read || mem.write);
	assign done  = busy_q && (lat_cnt == mmio_pkg::ram_lat_last);

	assign mem.busy  = busy_q;
	assign mem.ready = !busy_q;
	assign mem.rdata = rdata_q;

	always_ff @(posedge clki) begin
		if (!rst_in) begin
			busy_q  <= 1'b0;
			lat_cnt <= '0;
		end else if (start) begin
			busy_q  <= 1'b1;
			lat_cnt <= '0;
		end else if (done) begin
			busy_q <= 1'b0;
		end else if (busy_q) begin
			lat_cnt <= lat_cnt + 1'b1;
		end
	end

	// request latched at the strobe, acted on at the end of the wait
	always_ff @(posedge clki) begin
		if (start) begin
			req_addr  <= mem.addr;
			req_wdata <= mem.wdata;
			req_write <= mem.write;
		end
		if (done) begin
			if (req_write) begin
				mem_array[req_addr] <= req_wdata;
			end else begin
				rdata_q <= mem_array[req_addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mmio_top.sv ====
// Host side is a plain strobe bus; peripherals take the low data byte, chip select takes bit 0.
`default_nettype none

module mmio_top (
	input  logic                        clki,
	input  logic                        rst_in,
	input  logic [mmio_pkg::addr_w-1:0] addr,
	input  logic [mmio_pkg::data_w-1:0] wdata,
	input  logic                        read,
	input  logic                        write,
	input  logic [7:0]                  buttons,
	input  logic                        uart_rx,
	input  logic                        spi_miso,
	output logic [mmio_pkg::data_w-1:0] rdata,
	output logic                        ready,
	output logic                        busy,
	output logic                        uart_tx,
	output logic                        spi_clk,
	output logic                        spi_mosi,
	output logic                        spi_cs,
	output logic                        freq_out
);

	logic [7:0] rx_data;
	logic       rx_new;
	logic       tx_ready;
	logic [7:0] spi_rx;
	logic       spi_ready;
	logic       uart_write;
	logic       uart_read;
	logic       spi_write;
	logic       spi_cs_write;
	logic       tone_period_write;
	logic       tone_en_write;

	mem_bus_if mem_bus_i ();

	io_decoder io_decoder_i (
		.clki              (clki),
		.rst_in            (rst_in),
		.addr              (addr),
		.wdata             (wdata),
		.read              (read),
		.write             (write),
		.buttons           (buttons),
		.rx_data           (rx_data),
		.rx_new            (rx_new),
		.tx_ready          (tx_ready),
		.spi_rx            (spi_rx),
		.spi_ready         (spi_ready),
		.rdata             (rdata),
		.ready             (ready),
		.busy              (busy),
		.uart_write        (uart_write),
		.uart_read         (uart_read),
		.spi_write         (spi_write),
		.spi_cs_write      (spi_cs_write),
		.tone_period_write (tone_period_write),
		.tone_en_write     (tone_en_write),
		.mem               (mem_bus_i.ctrl)
	);

	uart_port uart_port_i (
		.clki       (clki),
		.rst_in     (rst_in),
		.uart_rx    (uart_rx),
		.tx_byte    (wdata[7:0]),
		.uart_write (uart_write),
		.uart_read  (uart_read),
		.uart_tx    (uart_tx),
		.rx_data    (rx_data),
		.rx_new     (rx_new),
		.tx_ready   (tx_ready)
	);

	spi_master spi_master_i (
		.clki         (clki),
		.rst_in       (rst_in),
		.tx_byte      (wdata[7:0]),
		.spi_write    (spi_write),
		.spi_cs_write (spi_cs_write),
		.cs_bit       (wdata[0]),
		.spi_miso     (spi_miso),
		.spi_clk      (spi_clk),
		.spi_mosi     (spi_mosi),
		.spi_cs       (spi_cs),
		.spi_rx       (spi_rx),
		.spi_ready    (spi_ready)
	);

	tone_gen tone_gen_i (
		.clki              (clki),
		.rst_in            (rst_in),
		.wdata             (wdata),
		.tone_period_write (tone_period_write),
		.tone_en_write     (tone_en_write),
		.freq_out          (freq_out)
	);

	wait_ram wait_ram_i (
		.clki   (clki),
		.rst_in (rst_in),
		.mem    (mem_bus_i.mem)
	);

endmodule

`default_nettype wire

// ==== verification/mmio_tb.sv ====
// Needs the UART and SPI loopbacks below; RAM contents are only checked after the testbench writes them.
`default_nettype none

module mmio_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] seed        = 32'hb870_649f;
	localparam int          wait_limit  = 200;
	localparam int          poll_limit  = 100;
	localparam int          ram_words_n = 16;

	logic                        clki;
	logic                        rst_in;
	logic [mmio_pkg::addr_w-1:0] host_addr;
	logic [mmio_pkg::data_w-1:0] host_wdata;
	logic                        host_read;
	logic                        host_write;
	logic [7:0]                  buttons;
	logic                        uart_rx;
	logic                        spi_miso;
	logic [mmio_pkg::data_w-1:0] rdata;
	logic                        ready;
	logic                        busy;
	logic                        uart_tx;
	logic                        spi_clk;
	logic                        spi_mosi;
	logic                        spi_cs;
	logic                        freq_out;

	int                          errors;
	int                          checks;
	logic [31:0]                 lcg_state;
	logic [mmio_pkg::data_w-1:0] ram_words [0:ram_words_n-1];

	// loopbacks held idle during reset
	assign uart_rx  = rst_in ? uart_tx : 1'b1;
	assign spi_miso = rst_in ? spi_mosi : 1'b0;

	mmio_top mmio_top_i (
		.clki     (clki),
		.rst_in   (rst_in),
		.addr     (host_addr),
		.wdata    (host_wdata),
		.read     (host_read),
		.write    (host_write),
		.buttons  (buttons),
		.uart_rx  (uart_rx),
		.spi_miso (spi_miso),
		.rdata    (rdata),
		.ready    (ready),
		.busy     (busy),
		.uart_tx  (uart_tx),
		.spi_clk  (spi_clk),
		.spi_mosi (spi_mosi),
		.spi_cs   (spi_cs),
		.freq_out (freq_out)
	);

	initial begin
		clki = 1'b0;
		forever #10 clki = !clki;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic finish_run();
		$display("errors: %0d in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timed out at %0t while waiting for %s", $time, what);
		errors++;
		finish_run();
	endtask

	task automatic check_word(input string name, input logic [mmio_pkg::data_w-1:0] got,
			input logic [mmio_pkg::data_w-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// outputs sampled on the falling edge away from the driving edge
	task automatic wait_ready(output logic saw_busy);
		int n;
		logic done;
		n = 0;
		done = 1'b0;
		saw_busy = 1'b0;
		while (!done) begin
			if (n == wait_limit) begin
				abort_on_timeout("ready");
			end
			@(negedge clki);
			if (busy) begin
				saw_busy = 1'b1;
			end
			done = ready;
			n++;
		end
	endtask

	task automatic bus_write(input logic [mmio_pkg::addr_w-1:0] a,
			input logic [mmio_pkg::data_w-1:0] d, output logic saw_busy);
		@(posedge clki);
		host_addr  <= a;
		host_wdata <= d;
		host_write <= 1'b1;
		@(posedge clki);
		host_write <= 1'b0;
		wait_ready(saw_busy);
	endtask

	task automatic bus_read(input logic [mmio_pkg::addr_w-1:0] a,
			output logic [mmio_pkg::data_w-1:0] d, output logic saw_busy);
		@(posedge clki);
		host_addr <= a;
		host_read <= 1'b1;
		@(posedge clki);
		host_read <= 1'b0;
		wait_ready(saw_busy);
		d = rdata;
	endtask

	task automatic reset_map_test();
		logic [mmio_pkg::data_w-1:0] d;
		logic seen;
		@(negedge clki);
		check_bit("ready", ready, 1'b1);
		check_bit("busy", busy, 1'b0);
		check_bit("uart_tx", uart_tx, 1'b1);
		check_bit("spi_cs", spi_cs, 1'b1);
		check_bit("spi_clk", spi_clk, 1'b0);
		check_bit("freq_out", freq_out, 1'b0);
		lcg_state = lcg_step(lcg_state);
		@(posedge clki);
		buttons <= lcg_state[31:24];
		bus_read(mmio_pkg::addr_buttons, d, seen);
		check_word("buttons read", d, {8'h00, lcg_state[31:24]});
		bus_read(16'h0003, d, seen);
		check_word("unmapped 0x0003", d, 16'h0000);
		bus_read(16'h00f0, d, seen);
		check_word("unmapped 0x00f0", d, 16'h0000);
	endtask

	task automatic uart_test();
		logic [7:0] b;
		logic [mmio_pkg::data_w-1:0] d;
		logic seen;
		int polls;
		lcg_state = lcg_step(lcg_state);
		b = lcg_state[23:16];
		bus_write(mmio_pkg::addr_uart_data, {8'h00, b}, seen);
		polls = 0;
		d = '0;
		while (!d[0]) begin
			if (polls == poll_limit) begin
				abort_on_timeout("a byte on the UART loopback");
			end
			bus_read(mmio_pkg::addr_uart_stat, d, seen);
			polls++;
		end
		bus_read(mmio_pkg::addr_uart_data, d, seen);
		check_word("uart rx data", d, {8'h00, b});
		// rx_new cleared by the data read and transmitter idle again
		bus_read(mmio_pkg::addr_uart_stat, d, seen);
		check_word("uart status", d, 16'h0002);
	endtask

	task automatic spi_test();
		logic [7:0] b;
		logic [mmio_pkg::data_w-1:0] d;
		logic seen;
		int polls;
		bus_write(mmio_pkg::addr_spi_cs, 16'h0000, seen);
		check_bit("spi_cs", spi_cs, 1'b0);
		lcg_state = lcg_step(lcg_state);
		b = lcg_state[15:8];
		bus_write(mmio_pkg::addr_spi_data, {8'h00, b}, seen);
		polls = 0;
		d = '0;
		while (!d[15]) begin
			if (polls == poll_limit) begin
				abort_on_timeout("the SPI transfer");
			end
			bus_read(mmio_pkg::addr_spi_data, d, seen);
			polls++;
		end
		check_word("spi data", d, {8'h80, b});
		check_bit("spi_clk idle", spi_clk, 1'b0);
		bus_write(mmio_pkg::addr_spi_cs, 16'h0001, seen);
		check_bit("spi_cs", spi_cs, 1'b1);
	endtask

	task automatic measure_half_period(output int cycles);
		logic prev;
		int n;
		n = 0;
		@(negedge clki);
		prev = freq_out;
		while (freq_out == prev) begin
			if (n == wait_limit) begin
				abort_on_timeout("a freq_out edge");
			end
			@(negedge clki);
			n++;
		end
		prev = freq_out;
		cycles = 0;
		while (freq_out == prev) begin
			if (cycles == wait_limit) begin
				abort_on_timeout("the next freq_out edge");
			end
			@(negedge clki);
			cycles++;
		end
	endtask

	task automatic wait_freq_high();
		int n;
		n = 0;
		@(negedge clki);
		while (freq_out !== 1'b1) begin
			if (n == wait_limit) begin
				abort_on_timeout("freq_out to go high");
			end
			@(negedge clki);
			n++;
		end
	endtask

	task automatic tone_test();
		logic [mmio_pkg::data_w-1:0] p;
		logic seen;
		int cycles;
		lcg_state = lcg_step(lcg_state);
		p = 16'd3 + 16'(lcg_state[10:8]);
		bus_write(mmio_pkg::addr_tone_period, p, seen);
		bus_write(mmio_pkg::addr_tone_en, 16'h0001, seen);
		repeat (2) begin
			measure_half_period(cycles);
			check_count("tone half period", cycles, int'(p) + 1);
		end
		// disable while the output is high
		wait_freq_high();
		bus_write(mmio_pkg::addr_tone_en, 16'h0000, seen);
		check_bit("freq_out", freq_out, 1'b0);
	endtask

	// low byte of i*0x111 differs for every i, so no two words alias
	function automatic logic [mmio_pkg::addr_w-1:0] ram_addr(input int i);
		return mmio_pkg::ram_base + 16'(i * 16'h0111);
	endfunction

	task automatic ram_test();
		logic [mmio_pkg::data_w-1:0] d;
		logic seen;
		for (int i = 0; i < ram_words_n; i++) begin
			lcg_state = lcg_step(lcg_state);
			ram_words[i] = lcg_state[15:0];
			bus_write(ram_addr(i), ram_words[i], seen);
			check_bit("busy during ram write", seen, 1'b1);
		end
		for (int i = 0; i < ram_words_n; i++) begin
			bus_read(ram_addr(i), d, seen);
			check_word("ram read", d, ram_words[i]);
			check_bit("busy during ram read", seen, 1'b1);
		end
	endtask

	task automatic back_pressure_test();
		logic seen;
		@(posedge clki);
		host_addr <= ram_addr(5);
		host_read <= 1'b1;
		@(posedge clki);
		host_read  <= 1'b0;
		host_addr  <= mmio_pkg::addr_spi_cs;
		host_wdata <= 16'h0000;
		host_write <= 1'b1;
		@(posedge clki);
		host_write <= 1'b0;
		host_addr  <= ram_addr(5);
		wait_ready(seen);
		check_word("ram read under back-pressure", rdata, ram_words[5]);
		check_bit("busy during pending read", seen, 1'b1);
		check_bit("spi_cs after dropped write", spi_cs, 1'b1);
	endtask

	initial begin
		errors     = 0;
		checks     = 0;
		lcg_state  = seed;
		rst_in     = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		host_read  = 1'b0;
		host_write = 1'b0;
		buttons    = 8'h00;
		repeat (4) @(posedge clki);
		rst_in <= 1'b1;
		reset_map_test();
		uart_test();
		spi_test();
		tone_test();
		ram_test();
		back_pressure_test();
		finish_run();
	end

endmodule

`default_nettype wire

// ==== mmio_top.f ====
hdl/mmio_pkg.sv
hdl/mem_bus_if.sv
hdl/io_decoder.sv
hdl/uart_port.sv
hdl/spi_master.sv
hdl/tone_gen.sv
hdl/wait_ram.sv
hdl/mmio_top.sv
verification/mmio_tb.sv
